/* common/fifo_params.svh */
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// Width of one stored word
`define FIFO_DATA_WIDTH 8

// Number of entries, must be a power of two
`define FIFO_DEPTH 8

// Almost-full when free entries are at or below this margin
`define FIFO_ALMOST_WR_MARGIN 1

// Almost-empty when occupancy is at or below this margin
`define FIFO_ALMOST_RD_MARGIN 1

`endif

/* common/fifo_pkg.sv */
`include "fifo_params.svh"

package fifo_pkg;

    //////////////////////////////////////////////////////////////////////
    // Derived widths

    localparam int ADDR_WIDTH = $clog2(`FIFO_DEPTH);
    localparam int DATA_WIDTH = `FIFO_DATA_WIDTH;

    //////////////////////////////////////////////////////////////////////
    // Types shared by the FIFO blocks

    // Memory address, low bits of a pointer
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Pointer with the extra wrap bit on top
    typedef logic [ADDR_WIDTH:0] ptr_t;

    // Occupancy, wide enough to hold a full FIFO
    typedef logic [ADDR_WIDTH:0] count_t;

    // One data word
    typedef logic [DATA_WIDTH-1:0] data_t;

endpackage : fifo_pkg

/* common/fifo_status_if.sv */
`timescale 1ns/1ps

// Pointer and status bundle between the FIFO core and its flag logic
interface fifo_status_if;

    import fifo_pkg::*;

    // Next-state pointers from the core
    ptr_t   wr_ptr_next;
    ptr_t   rd_ptr_next;

    // Registered status from the control block
    count_t count;
    logic   full;
    logic   almost_full;
    logic   empty;
    logic   almost_empty;

    // FIFO core side
    modport core (
        output wr_ptr_next,
        output rd_ptr_next,
        input  count,
        input  full,
        input  almost_full,
        input  empty,
        input  almost_empty
    );

    // Flag and count generation side
    modport ctrl (
        input  wr_ptr_next,
        input  rd_ptr_next,
        output count,
        output full,
        output almost_full,
        output empty,
        output almost_empty
    );

endinterface : fifo_status_if

/* source/counter_bin.sv */
`timescale 1ns/1ps
`include "fifo_params.svh"

module counter_bin (
    input  logic           i_axi_aclk,
    input  logic           i_axi_aresetn,
    input  logic           i_enable,
    output fifo_pkg::ptr_t o_counter_bin,
    output fifo_pkg::ptr_t ow_counter_bin_next
);

    import fifo_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'(`FIFO_DEPTH - 1);

    addr_t w_addr;
    logic  w_wrap_bit;

    assign w_addr     = o_counter_bin[ADDR_WIDTH-1:0];
    assign w_wrap_bit = o_counter_bin[ADDR_WIDTH];

    //////////////////////////////////////////////////////////////////////
    // Next value seen before the edge by the flag logic

    always_comb begin
        ow_counter_bin_next = o_counter_bin;
        if (i_enable) begin
            if (w_addr == LAST_ADDR) begin
                // Address wraps and the wrap bit flips
                ow_counter_bin_next = {~w_wrap_bit, {ADDR_WIDTH{1'b0}}};
            end else begin
                ow_counter_bin_next = {w_wrap_bit, w_addr + addr_t'(1)};
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointer register

    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            o_counter_bin <= '0;
        end else begin
            o_counter_bin <= ow_counter_bin_next;
        end
    end

endmodule : counter_bin

/* axi_fifo_sync/fifo_control.sv */
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_control (
    input  logic          i_axi_aclk,
    input  logic          i_axi_aresetn,
    fifo_status_if.ctrl   status
);

    import fifo_pkg::*;

    localparam count_t DEPTH_COUNT = count_t'(`FIFO_DEPTH);
    localparam count_t WR_MARGIN   = count_t'(`FIFO_ALMOST_WR_MARGIN);
    localparam count_t RD_MARGIN   = count_t'(`FIFO_ALMOST_RD_MARGIN);

    addr_t  w_wr_addr;
    addr_t  w_rd_addr;
    logic   w_wr_wrap;
    logic   w_rd_wrap;
    count_t w_count;
    count_t w_free;
    logic   w_full;
    logic   w_empty;
    logic   w_almost_full;
    logic   w_almost_empty;

    //////////////////////////////////////////////////////////////////////
    // Split the next pointers into address and wrap bit

    assign w_wr_addr = status.wr_ptr_next[ADDR_WIDTH-1:0];
    assign w_rd_addr = status.rd_ptr_next[ADDR_WIDTH-1:0];
    assign w_wr_wrap = status.wr_ptr_next[ADDR_WIDTH];
    assign w_rd_wrap = status.rd_ptr_next[ADDR_WIDTH];

    //////////////////////////////////////////////////////////////////////
    // Occupancy from the pointer difference

    // Modulo arithmetic covers the wrap case
    assign w_count = count_t'(status.wr_ptr_next - status.rd_ptr_next);
    assign w_free  = DEPTH_COUNT - w_count;

    // Same slot, different lap
    assign w_full  = (w_wr_addr == w_rd_addr) && (w_wr_wrap != w_rd_wrap);
    // Same slot, same lap
    assign w_empty = (status.wr_ptr_next == status.rd_ptr_next);

    assign w_almost_full  = (w_free <= WR_MARGIN);
    assign w_almost_empty = (w_count <= RD_MARGIN);

    //////////////////////////////////////////////////////////////////////
    // Registered status

    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            status.count        <= '0;
            status.full         <= 1'b0;
            status.almost_full  <= 1'b0;
            status.empty        <= 1'b1;
            status.almost_empty <= 1'b1;
        end else begin
            status.count        <= w_count;
            status.full         <= w_full;
            status.almost_full  <= w_almost_full;
            status.empty        <= w_empty;
            status.almost_empty <= w_almost_empty;
        end
    end

endmodule : fifo_control

/* axi_fifo_sync/axi_fifo_sync.sv */
`timescale 1ns/1ps
`include "fifo_params.svh"

module axi_fifo_sync (
    input  logic             i_axi_aclk,
    input  logic             i_axi_aresetn,
    input  logic             i_wr_valid,
    output logic             o_wr_ready,
    input  fifo_pkg::data_t  i_wr_data,
    input  logic             i_rd_ready,
    output logic             o_rd_valid,
    output fifo_pkg::data_t  ow_rd_data,
    output fifo_pkg::data_t  o_rd_data,
    output fifo_pkg::count_t o_count,
    output logic             o_almost_full,
    output logic             o_almost_empty
);

    import fifo_pkg::*;

    ptr_t  r_wr_ptr;
    ptr_t  r_rd_ptr;
    addr_t w_wr_addr;
    addr_t w_rd_addr;
    logic  w_write;
    logic  w_read;

    // Payload storage
    data_t r_mem [`FIFO_DEPTH];

    fifo_status_if u_status ();

    //////////////////////////////////////////////////////////////////////
    // Handshake qualification

    // Ready and valid follow the registered full and empty flags
    assign w_write = i_wr_valid && o_wr_ready;
    assign w_read  = o_rd_valid && i_rd_ready;

    assign o_wr_ready     = !u_status.full;
    assign o_rd_valid     = !u_status.empty;
    assign o_count        = u_status.count;
    assign o_almost_full  = u_status.almost_full;
    assign o_almost_empty = u_status.almost_empty;

    //////////////////////////////////////////////////////////////////////
    // Pointers

    counter_bin u_wr_ptr (
        .i_axi_aclk          (i_axi_aclk),
        .i_axi_aresetn       (i_axi_aresetn),
        .i_enable            (w_write),
        .o_counter_bin       (r_wr_ptr),
        .ow_counter_bin_next (u_status.wr_ptr_next)
    );

    counter_bin u_rd_ptr (
        .i_axi_aclk          (i_axi_aclk),
        .i_axi_aresetn       (i_axi_aresetn),
        .i_enable            (w_read),
        .o_counter_bin       (r_rd_ptr),
        .ow_counter_bin_next (u_status.rd_ptr_next)
    );

    //////////////////////////////////////////////////////////////////////
    // Flags and count

    fifo_control u_control (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .status        (u_status)
    );

    //////////////////////////////////////////////////////////////////////
    // Storage and read paths

    assign w_wr_addr = r_wr_ptr[ADDR_WIDTH-1:0];
    assign w_rd_addr = r_rd_ptr[ADDR_WIDTH-1:0];

    always_ff @(posedge i_axi_aclk) begin
        if (w_write) begin
            r_mem[w_wr_addr] <= i_wr_data;
        end
    end

    // Combinational head entry
    assign ow_rd_data = r_mem[w_rd_addr];

    // Head entry one cycle late
    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (!i_axi_aresetn) begin
            o_rd_data <= '0;
        end else begin
            o_rd_data <= ow_rd_data;
        end
    end

endmodule : axi_fifo_sync

/* source/axi_fifo_top.sv */
`timescale 1ns/1ps

module axi_fifo_top (
    input  logic             i_axi_aclk,
    input  logic             i_axi_aresetn,
    // Write side
    input  logic             i_wr_valid,
    output logic             o_wr_ready,
    input  fifo_pkg::data_t  i_wr_data,
    // Read side
    input  logic             i_rd_ready,
    output logic             o_rd_valid,
    output fifo_pkg::data_t  ow_rd_data,
    output fifo_pkg::data_t  o_rd_data,
    // Status
    output fifo_pkg::count_t o_count,
    output logic             o_almost_full,
    output logic             o_almost_empty
);

    //////////////////////////////////////////////////////////////////////
    // FIFO core

    axi_fifo_sync u_fifo (
        .i_axi_aclk     (i_axi_aclk),
        .i_axi_aresetn  (i_axi_aresetn),
        .i_wr_valid     (i_wr_valid),
        .o_wr_ready     (o_wr_ready),
        .i_wr_data      (i_wr_data),
        .i_rd_ready     (i_rd_ready),
        .o_rd_valid     (o_rd_valid),
        .ow_rd_data     (ow_rd_data),
        .o_rd_data      (o_rd_data),
        .o_count        (o_count),
        .o_almost_full  (o_almost_full),
        .o_almost_empty (o_almost_empty)
    );

endmodule : axi_fifo_top

/* testbench/tb_axi_fifo_top.sv */
`timescale 1ns/1ps
`include "fifo_params.svh"

module tb_axi_fifo_top;

    import fifo_pkg::*;

    localparam int     TIMEOUT_CYCLES = 200;
    localparam int     TRAFFIC_WORDS  = 240;
    localparam int     TRAFFIC_LIMIT  = 5000;
    localparam count_t DEPTH_COUNT    = count_t'(`FIFO_DEPTH);
    localparam count_t WR_MARGIN      = count_t'(`FIFO_ALMOST_WR_MARGIN);
    localparam count_t RD_MARGIN      = count_t'(`FIFO_ALMOST_RD_MARGIN);

    logic   i_axi_aclk = 1'b0;
    logic   i_axi_aresetn;
    logic   i_wr_valid;
    logic   o_wr_ready;
    data_t  i_wr_data;
    logic   i_rd_ready;
    logic   o_rd_valid;
    data_t  ow_rd_data;
    data_t  o_rd_data;
    count_t o_count;
    logic   o_almost_full;
    logic   o_almost_empty;

    // Reference model of the FIFO contents
    data_t       model_q [$];
    count_t      model_size = '0;
    data_t       model_head = '0;
    logic        wr_took    = 1'b0;
    int          rd_total   = 0;
    logic [31:0] lfsr_state = 32'h5dcedeea;

    int reset_errors        = 0;
    int order_errors        = 0;
    int count_errors        = 0;
    int flag_errors         = 0;
    int backpressure_errors = 0;
    int timeout_errors      = 0;
    int total_errors;

    axi_fifo_top i_axi_fifo_top (
        .i_axi_aclk     (i_axi_aclk),
        .i_axi_aresetn  (i_axi_aresetn),
        .i_wr_valid     (i_wr_valid),
        .o_wr_ready     (o_wr_ready),
        .i_wr_data      (i_wr_data),
        .i_rd_ready     (i_rd_ready),
        .o_rd_valid     (o_rd_valid),
        .ow_rd_data     (ow_rd_data),
        .o_rd_data      (o_rd_data),
        .o_count        (o_count),
        .o_almost_full  (o_almost_full),
        .o_almost_empty (o_almost_empty)
    );

    // 20 ns period
    always #10 i_axi_aclk = ~i_axi_aclk;

    //////////////////////////////////////////////////////////////////////
    // Reference model that follows every accepted handshake

    always @(posedge i_axi_aclk) begin : model_update
        logic wr_fire;
        logic rd_fire;
        wr_fire = 1'b0;
        rd_fire = 1'b0;
        if (i_axi_aresetn) begin
            if (o_rd_valid && i_rd_ready && model_q.size() > 0) begin
                void'(model_q.pop_front());
                rd_fire = 1'b1;
            end
            if (i_wr_valid && o_wr_ready) begin
                model_q.push_back(i_wr_data);
                wr_fire = 1'b1;
            end
        end
        wr_took    <= wr_fire;
        rd_total   <= rd_fire ? rd_total + 1 : rd_total;
        model_size <= count_t'(model_q.size());
        model_head <= (model_q.size() > 0) ? model_q[0] : '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks

    a_reset_state: assert property (@(posedge i_axi_aclk)
        !i_axi_aresetn |-> (o_count == '0 && !o_rd_valid && !o_almost_full
                            && o_rd_data == '0 && o_wr_ready && o_almost_empty))
    else begin
        $display("ERROR %0t: outputs not at their reset values", $time);
        reset_errors++;
    end

    // Head word must match the oldest word in the model
    a_head_word: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        (o_rd_valid && i_rd_ready) |-> (ow_rd_data == model_head))
    else begin
        $display("ERROR %0t: read word differs from the oldest written word", $time);
        order_errors++;
    end

    a_registered_word: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        (o_rd_valid && i_rd_ready) |=> (o_rd_data == $past(model_head)))
    else begin
        $display("ERROR %0t: registered read data differs from the word read", $time);
        order_errors++;
    end

    a_count: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        o_count == model_size)
    else begin
        $display("ERROR %0t: o_count is %0d, expected %0d", $time,
                 $sampled(o_count), $sampled(model_size));
        count_errors++;
    end

    a_rd_valid: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        o_rd_valid == (model_size != '0))
    else begin
        $display("ERROR %0t: o_rd_valid does not match the occupancy", $time);
        count_errors++;
    end

    a_wr_ready: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        o_wr_ready == (model_size < DEPTH_COUNT))
    else begin
        $display("ERROR %0t: o_wr_ready does not match the occupancy", $time);
        count_errors++;
    end

    a_almost_full: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        o_almost_full == ((DEPTH_COUNT - model_size) <= WR_MARGIN))
    else begin
        $display("ERROR %0t: o_almost_full does not match the free entries", $time);
        flag_errors++;
    end

    a_almost_empty: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        o_almost_empty == (model_size <= RD_MARGIN))
    else begin
        $display("ERROR %0t: o_almost_empty does not match the occupancy", $time);
        flag_errors++;
    end

    // A word offered to a full FIFO with reads held off is not taken
    a_full_hold: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        (i_wr_valid && !i_rd_ready && model_size == DEPTH_COUNT)
        |=> (o_count == DEPTH_COUNT && !o_wr_ready))
    else begin
        $display("ERROR %0t: a word was taken while the FIFO was full", $time);
        backpressure_errors++;
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic apply_reset();
        i_wr_valid    = 1'b0;
        i_wr_data     = '0;
        i_rd_ready    = 1'b0;
        i_axi_aresetn = 1'b1;
        #5;
        i_axi_aresetn = 1'b0;
        repeat (8) @(posedge i_axi_aclk);
        @(negedge i_axi_aclk);
        i_axi_aresetn = 1'b1;
    endtask

    task automatic wait_write_accept();
        int cycles;
        cycles = 0;
        while (timeout_errors == 0) begin
            @(negedge i_axi_aclk);
            if (wr_took) begin
                break;
            end
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: a write was never accepted by the FIFO");
                timeout_errors++;
            end
        end
    endtask

    task automatic wait_until_empty();
        int cycles;
        cycles = 0;
        while (timeout_errors == 0 && (o_rd_valid || model_size != '0)) begin
            @(negedge i_axi_aclk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: the FIFO did not drain to empty");
                timeout_errors++;
            end
        end
    endtask

    task automatic send_word();
        i_wr_data  = data_t'(take_bits(`FIFO_DATA_WIDTH));
        i_wr_valid = 1'b1;
        wait_write_accept();
        i_wr_valid = 1'b0;
    endtask

    // Fill with reads held off and then push one word against the full FIFO
    task automatic fill_and_block();
        i_rd_ready = 1'b0;
        for (int n = 0; n < `FIFO_DEPTH; n++) begin
            send_word();
        end
        i_wr_data  = data_t'(take_bits(`FIFO_DATA_WIDTH));
        i_wr_valid = 1'b1;
        repeat (6) @(negedge i_axi_aclk);
        i_rd_ready = 1'b1;
        wait_write_accept();
        i_wr_valid = 1'b0;
        wait_until_empty();
        i_rd_ready = 1'b0;
    endtask

    task automatic run_traffic(input int n_words);
        int sent;
        int cycles;
        int rd_goal;
        sent    = 0;
        cycles  = 0;
        rd_goal = rd_total + n_words;
        while (timeout_errors == 0 && rd_total < rd_goal) begin
            if (i_wr_valid && wr_took) begin
                sent++;
                i_wr_valid = 1'b0;
            end
            // Valid stays up until the word is taken
            if (!i_wr_valid && sent < n_words) begin
                if (take_bits(2) != 32'd0) begin
                    i_wr_data  = data_t'(take_bits(`FIFO_DATA_WIDTH));
                    i_wr_valid = 1'b1;
                end
            end
            i_rd_ready = (take_bits(1) != 32'd0);
            @(negedge i_axi_aclk);
            cycles++;
            if (cycles >= TRAFFIC_LIMIT) begin
                $display("Timeout: random traffic did not complete");
                timeout_errors++;
            end
        end
        i_wr_valid = 1'b0;
        i_rd_ready = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        apply_reset();
        fill_and_block();
        run_traffic(TRAFFIC_WORDS);
        wait_until_empty();
        // Room for the last registered read data check
        repeat (2) @(negedge i_axi_aclk);

        total_errors = reset_errors + order_errors + count_errors + flag_errors
                       + backpressure_errors + timeout_errors;
        $display("Error counts: reset %0d, order %0d, count %0d, flags %0d, %s %0d, %s %0d",
                 reset_errors, order_errors, count_errors, flag_errors,
                 "backpressure", backpressure_errors, "timeout", timeout_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_axi_fifo_top

/* build.f */
+incdir+common
common/fifo_pkg.sv
common/fifo_status_if.sv
source/counter_bin.sv
axi_fifo_sync/fifo_control.sv
axi_fifo_sync/axi_fifo_sync.sv
source/axi_fifo_top.sv
testbench/tb_axi_fifo_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f build.f \
    --top-module tb_axi_fifo_top \
    -o tb_axi_fifo_top

# Capture the simulation output for the pass search
sim_output=$(./obj_dir/tb_axi_fifo_top)
echo "$sim_output"

if echo "$sim_output" | grep -qx "All checks passed"; then
    echo "Simulation result: PASS"
    exit 0
else
    echo "Simulation result: FAIL"
    exit 1
fi
